//--- hdl/zx_pkg.sv
/*
 Shared types and constants for the memory and speed control core.
 Port decodes are partial, as on the real machines, so mirrors exist.
*/
package zx_pkg;

	// ==============================
	// Machine types
	// ==============================
	typedef enum logic [1:0] {
		MACH_48    = 2'd0,
		MACH_128   = 2'd1,
		MACH_PLUS3 = 2'd2
	} machine_t;

	// 7FFD paging register, whole byte or fields
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] unused;
			logic       lock;     // Paging frozen until reset
			logic       rom_sel;
			logic       screen;   // Shadow screen select
			logic [2:0] ram_bank; // Bank at C000
		} f;
	} page7ffd_u;

	localparam int RAM_ADDR_W = 24;

	// ==============================
	// Turbo masks
	// ==============================
	localparam int TURBO_W = 5;

	localparam logic [TURBO_W-1:0] TURBO_3M5 = 5'b11111;
	localparam logic [TURBO_W-1:0] TURBO_7M  = 5'b01111;
	localparam logic [TURBO_W-1:0] TURBO_14M = 5'b00111;
	localparam logic [TURBO_W-1:0] TURBO_28M = 5'b00011;
	localparam logic [TURBO_W-1:0] TURBO_56M = 5'b00001;

	// cpu_n events with the CPU off after a speed change
	localparam logic [1:0] SWITCH_WAIT = 2'd3;

	// ==============================
	// Port decode
	// ==============================
	localparam int PORT_FE_BIT = 0; // ULA port on any even address

	localparam logic [15:0] PORT_7FFD_MASK     = 16'h8002; // 128K decode, A15 and A1 low
	localparam logic [15:0] PORT_7FFD_MATCH    = 16'h0000;
	localparam logic [15:0] PORT_7FFD_P3_MASK  = 16'hC002; // +3 also needs A14 high
	localparam logic [15:0] PORT_7FFD_P3_MATCH = 16'h4000;
	localparam logic [15:0] PORT_1FFD_MASK     = 16'hF002;
	localparam logic [15:0] PORT_1FFD_MATCH    = 16'h1000;

endpackage

//--- hdl/ce_divider.sv
/*
 CPU phase enables from a free-running 6-bit counter.
 One ce_tp every 2*(turbo+1) clocks, ce_tn half a period later.
 A turbo change may give one short phase while the counter realigns.
*/
`timescale 1ns/1ns

module ce_divider (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [zx_pkg::TURBO_W-1:0] turbo,
	output logic                       ce_tp,
	output logic                       ce_tn
);

	logic [5:0] counter;
	logic [5:0] mask;
	logic [5:0] half;
	logic [5:0] phase;

	// Bit 0 always counted, so 56 MHz is every 4 clocks
	assign mask  = {turbo, 1'b1};
	assign half  = mask ^ (mask >> 1); // Top set bit of the mask
	assign phase = counter & mask;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			ce_tp   <= 1'b0;
			ce_tn   <= 1'b0;
		end else begin
			counter <= counter + 1'd1;
			ce_tp   <= (phase == 6'd0);
			ce_tn   <= (phase == half);
		end
	end

endmodule

//--- hdl/speed_ctrl.sv
/*
 Turbo selection and CPU enable gating.
 speed_key and pause_key are one-cycle pulses, one bit per speed.
 Decisions are taken only on ce_tn, the raw cpu_n event.
*/
`timescale 1ns/1ns

module speed_ctrl (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [4:0]                 speed_key,
	input  logic                       pause_key,
	input  logic                       ram_ready,
	input  logic                       ce_tp,
	input  logic                       ce_tn,
	output logic [zx_pkg::TURBO_W-1:0] turbo,
	output logic                       ce_cpu_p,
	output logic                       ce_cpu_n,
	output logic                       cpu_en
);

	localparam logic [1:0] RUN    = 2'd0;
	localparam logic [1:0] SWITCH = 2'd1;
	localparam logic [1:0] HOLD   = 2'd2;

	logic [1:0]                 state;
	logic [1:0]                 wait_cnt;
	logic [zx_pkg::TURBO_W-1:0] turbo_req;
	logic                       pause;
	logic                       fast;

	assign fast     = ~|turbo[zx_pkg::TURBO_W-1 -: 2]; // 14 MHz and up
	assign cpu_en   = (state == RUN);
	assign ce_cpu_p = ce_tp & cpu_en;
	assign ce_cpu_n = ce_tn & cpu_en;

	// Key requests, the last bit wins
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			turbo_req <= zx_pkg::TURBO_3M5;
			pause     <= 1'b0;
		end else begin
			if (speed_key[0]) turbo_req <= zx_pkg::TURBO_3M5;
			if (speed_key[1]) turbo_req <= zx_pkg::TURBO_7M;
			if (speed_key[2]) turbo_req <= zx_pkg::TURBO_14M;
			if (speed_key[3]) turbo_req <= zx_pkg::TURBO_28M;
			if (speed_key[4]) turbo_req <= zx_pkg::TURBO_56M;
			if (pause_key)    pause <= ~pause;
		end
	end

	// ==============================
	// Enable FSM
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= RUN;
			turbo    <= zx_pkg::TURBO_3M5;
			wait_cnt <= 2'd0;
		end else if (ce_tn) begin
			if (turbo != turbo_req) begin // New speed restarts the wait
				turbo    <= turbo_req;
				wait_cnt <= zx_pkg::SWITCH_WAIT;
				state    <= SWITCH;
			end else begin
				case (state)
					RUN: begin
						if ((fast & ~ram_ready) | pause)
							state <= HOLD;
					end
					SWITCH: begin
						wait_cnt <= wait_cnt - 1'd1;
						if (wait_cnt == 2'd1)
							state <= HOLD;
					end
					HOLD: begin
						if (ram_ready & ~pause)
							state <= RUN;
					end
					default: state <= HOLD;
				endcase
			end
		end
	end

endmodule

//--- hdl/page_regs.sv
/*
 Paging registers 7FFD and 1FFD and the ULA output port FE.
 io_wr_edge is one cycle long; cpu_addr and cpu_dout are valid with it.
 The machine type is taken from machine_in only while reset is high.
*/
`timescale 1ns/1ns

module page_regs (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::machine_t  machine_in,
	input  logic [15:0]       cpu_addr,
	input  logic [7:0]        cpu_dout,
	input  logic              io_wr_edge,
	output zx_pkg::machine_t  machine,
	output zx_pkg::page7ffd_u page7ffd,
	output logic [7:0]        page1ffd,
	output logic [2:0]        border_color,
	output logic              ear_out,
	output logic              mic_out
);

	logic is_plus3;
	logic page_disable;
	logic sel_fe;
	logic sel_7ffd;
	logic sel_1ffd;

	assign is_plus3     = (machine == zx_pkg::MACH_PLUS3);
	assign page_disable = (machine == zx_pkg::MACH_48) | page7ffd.f.lock;

	// ==============================
	// Port decode
	// ==============================
	assign sel_fe = ~cpu_addr[zx_pkg::PORT_FE_BIT];

	always_comb begin
		if (is_plus3)
			sel_7ffd = (cpu_addr & zx_pkg::PORT_7FFD_P3_MASK) == zx_pkg::PORT_7FFD_P3_MATCH;
		else
			sel_7ffd = (cpu_addr & zx_pkg::PORT_7FFD_MASK) == zx_pkg::PORT_7FFD_MATCH;
	end

	// Only the +3 has the second paging port
	assign sel_1ffd = is_plus3 &
		((cpu_addr & zx_pkg::PORT_1FFD_MASK) == zx_pkg::PORT_1FFD_MATCH);

	// Paging registers
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			machine      <= machine_in;
			page7ffd.raw <= 8'h00;
			page1ffd     <= 8'h00;
		end else if (io_wr_edge & ~page_disable) begin
			if (sel_7ffd)
				page7ffd.raw <= cpu_dout;
			else if (sel_1ffd)
				page1ffd <= cpu_dout;
		end
	end

	// ULA output port
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (io_wr_edge & sel_fe) begin
			border_color <= cpu_dout[2:0];
			mic_out      <= cpu_dout[3];
			ear_out      <= cpu_dout[4];
		end
	end

endmodule

//--- hdl/mem_map.sv
/*
 CPU address to external RAM address, purely combinational.
 ROM pages sit under ROM_BASE, RAM banks at the bottom of the space.
*/
`timescale 1ns/1ns

module mem_map #(
	parameter logic [2:0] ROM_BASE = 3'b101
) (
	input  logic [15:0]                   cpu_addr,
	input  logic                          mem_wr,
	input  zx_pkg::machine_t              machine,
	input  zx_pkg::page7ffd_u             page7ffd,
	input  logic [7:0]                    page1ffd,
	output logic [zx_pkg::RAM_ADDR_W-1:0] ram_addr,
	output logic                          ram_we
);

	logic        special;
	logic        rom_win;
	logic [1:0]  quad;
	logic [1:0]  rom_page;
	logic [2:0]  bank;
	logic [13:0] offset;

	assign quad    = cpu_addr[15:14];
	assign offset  = cpu_addr[13:0];
	assign special = (machine == zx_pkg::MACH_PLUS3) & page1ffd[0]; // All-RAM mode
	assign rom_win = (quad == 2'b00) & ~special;

	always_comb begin
		case (machine)
			zx_pkg::MACH_48:    rom_page = 2'd3;
			zx_pkg::MACH_PLUS3: rom_page = {page1ffd[2], page7ffd.f.rom_sel};
			default:            rom_page = {1'b1, page7ffd.f.rom_sel};
		endcase
	end

	// ==============================
	// Bank select
	// ==============================
	always_comb begin
		if (special) begin
			case (page1ffd[2:1])
				2'b00: bank = {1'b0, quad}; // 0 1 2 3
				2'b01: bank = {1'b1, quad}; // 4 5 6 7
				default: begin
					bank = {1'b1, quad};
					if (quad == 2'b11)
						bank = 3'd3;
					else if ((quad == 2'b01) && page1ffd[1])
						bank = 3'd7; // 4 7 6 3
				end
			endcase
		end else begin
			case (quad)
				2'b01:   bank = 3'd5;
				2'b10:   bank = 3'd2;
				2'b11:   bank = page7ffd.f.ram_bank;
				default: bank = 3'd0; // ROM window, not used
			endcase
		end
	end

	always_comb begin
		if (rom_win)
			ram_addr = {{(zx_pkg::RAM_ADDR_W-21){1'b0}}, ROM_BASE, 2'b00, rom_page, offset};
		else
			ram_addr = {{(zx_pkg::RAM_ADDR_W-17){1'b0}}, bank, offset};
	end

	assign ram_we = mem_wr & ~rom_win; // ROM is write protected

endmodule

//--- hdl/zx_mem_ctrl.sv
/*
 Memory and speed control core, top level.
 Hold cpu_addr and cpu_dout for two cycles after io_wr rises.
 The new mapping appears two cycles after the io_wr edge.
*/
`timescale 1ns/1ns

module zx_mem_ctrl #(
	parameter logic [2:0] ROM_BASE = 3'b101
) (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  zx_pkg::machine_t              machine,
	input  logic [15:0]                   cpu_addr,
	input  logic [7:0]                    cpu_dout,
	input  logic                          io_wr,
	input  logic                          mem_wr,
	input  logic [4:0]                    speed_key,
	input  logic                          pause_key,
	input  logic                          ram_ready,
	output logic [zx_pkg::RAM_ADDR_W-1:0] ram_addr,
	output logic                          ram_we,
	output logic                          ce_cpu_p,
	output logic                          ce_cpu_n,
	output logic                          cpu_en,
	output logic [2:0]                    border_color,
	output logic                          ear_out,
	output logic                          mic_out
);

	logic                       io_wr_d;
	logic                       io_wr_edge;
	logic [zx_pkg::TURBO_W-1:0] turbo;
	logic                       ce_tp;
	logic                       ce_tn;
	zx_pkg::machine_t           mach_q;
	zx_pkg::page7ffd_u          page7ffd;
	logic [7:0]                 page1ffd;

	// io_wr rising edge, registered
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d    <= 1'b0;
			io_wr_edge <= 1'b0;
		end else begin
			io_wr_d    <= io_wr;
			io_wr_edge <= io_wr & ~io_wr_d;
		end
	end

	// ==============================
	// Clocking
	// ==============================
	ce_divider u_ce_divider (
		.clk_sys (clk_sys),
		.reset   (reset),
		.turbo   (turbo),
		.ce_tp   (ce_tp),
		.ce_tn   (ce_tn)
	);

	speed_ctrl u_speed_ctrl (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.speed_key (speed_key),
		.pause_key (pause_key),
		.ram_ready (ram_ready),
		.ce_tp     (ce_tp),
		.ce_tn     (ce_tn),
		.turbo     (turbo),
		.ce_cpu_p  (ce_cpu_p),
		.ce_cpu_n  (ce_cpu_n),
		.cpu_en    (cpu_en)
	);

	// ==============================
	// Paging
	// ==============================
	page_regs u_page_regs (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine_in   (machine),
		.cpu_addr     (cpu_addr),
		.cpu_dout     (cpu_dout),
		.io_wr_edge   (io_wr_edge),
		.machine      (mach_q),
		.page7ffd     (page7ffd),
		.page1ffd     (page1ffd),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	mem_map #(
		.ROM_BASE (ROM_BASE)
	) u_mem_map (
		.cpu_addr (cpu_addr),
		.mem_wr   (mem_wr),
		.machine  (mach_q),
		.page7ffd (page7ffd),
		.page1ffd (page1ffd),
		.ram_addr (ram_addr),
		.ram_we   (ram_we)
	);

endmodule

//--- tests/tb_vectors.svh
/*
 Paging and ULA port table, one port write and one probe per row.
 Columns: rst, machine, port, data, probe, mem_wr, ram_addr, ram_we, ula.
 ula is {ear, mic, border}. Rows with rst clear keep the state of the row before.
*/
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
	logic             rst;      // Reset with mach first
	zx_pkg::machine_t mach;
	logic [15:0]      port;
	logic [7:0]       data;
	logic [15:0]      probe;
	logic             wr;       // mem_wr during the probe
	logic [23:0]      exp_addr;
	logic             exp_we;
	logic [4:0]       exp_ula;
} vec_t;

localparam int NUM_VECS = 23;

localparam zx_pkg::machine_t M48  = zx_pkg::MACH_48;
localparam zx_pkg::machine_t M128 = zx_pkg::MACH_128;
localparam zx_pkg::machine_t MP3  = zx_pkg::MACH_PLUS3;

vec_t vecs [NUM_VECS];

// RAM bank location of a CPU address
function automatic logic [23:0] bank_loc(input logic [2:0] bank, input logic [15:0] addr);
	return {7'd0, bank, addr[13:0]};
endfunction

// ROM page location under ROM_BASE
function automatic logic [23:0] rom_loc(input logic [1:0] page, input logic [15:0] addr);
	return {3'd0, ROM_BASE, 2'd0, page, addr[13:0]};
endfunction

function automatic vec_t row(input logic rst, input zx_pkg::machine_t mach,
		input logic [15:0] port, input logic [7:0] data, input logic [15:0] probe,
		input logic wr, input logic [23:0] exp_addr, input logic exp_we,
		input logic [4:0] exp_ula);
	return '{rst, mach, port, data, probe, wr, exp_addr, exp_we, exp_ula};
endfunction

function automatic void fill_vectors();
	// 128K paging, bank 3 at C000
	vecs[0]  = row(1, M128, 16'h7FFD, 8'h03, 16'hC123, 0, bank_loc(3, 16'hC123), 0, 5'h00);
	vecs[1]  = row(0, M128, 16'h7FFD, 8'h03, 16'h4567, 0, bank_loc(5, 16'h4567), 0, 5'h00);
	vecs[2]  = row(0, M128, 16'h7FFD, 8'h03, 16'h8ABC, 1, bank_loc(2, 16'h8ABC), 1, 5'h00);
	vecs[3]  = row(0, M128, 16'h7FFD, 8'h03, 16'h0040, 0, rom_loc(2, 16'h0040), 0, 5'h00);
	// Lock with bank 4 and ROM 1, then a write that must be ignored
	vecs[4]  = row(1, M128, 16'h7FFD, 8'h34, 16'hC010, 0, bank_loc(4, 16'hC010), 0, 5'h00);
	vecs[5]  = row(0, M128, 16'h7FFD, 8'h07, 16'hC010, 0, bank_loc(4, 16'hC010), 0, 5'h00);
	vecs[6]  = row(0, M128, 16'h7FFD, 8'h07, 16'h0010, 0, rom_loc(3, 16'h0010), 0, 5'h00);
	vecs[7]  = row(1, M128, 16'h7FFD, 8'h07, 16'hC010, 0, bank_loc(7, 16'hC010), 0, 5'h00);
	// 48K has no paging
	vecs[8]  = row(1, M48,  16'h7FFD, 8'h07, 16'hC010, 0, bank_loc(0, 16'hC010), 0, 5'h00);
	vecs[9]  = row(0, M48,  16'h7FFD, 8'h17, 16'h0200, 1, rom_loc(3, 16'h0200), 0, 5'h00);
	// +3 special paging, sets 4-5-6-3, 4-7-6-3 and 0-1-2-3
	vecs[10] = row(1, MP3,  16'h1FFD, 8'h05, 16'h0123, 1, bank_loc(4, 16'h0123), 1, 5'h00);
	vecs[11] = row(0, MP3,  16'h1FFD, 8'h05, 16'h4123, 0, bank_loc(5, 16'h4123), 0, 5'h00);
	vecs[12] = row(0, MP3,  16'h1FFD, 8'h05, 16'h8123, 0, bank_loc(6, 16'h8123), 0, 5'h00);
	vecs[13] = row(0, MP3,  16'h1FFD, 8'h05, 16'hC123, 1, bank_loc(3, 16'hC123), 1, 5'h00);
	vecs[14] = row(0, MP3,  16'h1FFD, 8'h07, 16'h4123, 0, bank_loc(7, 16'h4123), 0, 5'h00);
	vecs[15] = row(0, MP3,  16'h1FFD, 8'h01, 16'h4123, 0, bank_loc(1, 16'h4123), 0, 5'h00);
	// +3 normal paging, ROM page from 1FFD bit 2 and rom_sel
	vecs[16] = row(1, MP3,  16'h1FFD, 8'h04, 16'h0100, 1, rom_loc(2, 16'h0100), 0, 5'h00);
	vecs[17] = row(0, MP3,  16'h7FFD, 8'h16, 16'h0100, 0, rom_loc(3, 16'h0100), 0, 5'h00);
	// ROM select and write protection
	vecs[18] = row(1, M128, 16'h7FFD, 8'h00, 16'h1234, 1, rom_loc(2, 16'h1234), 0, 5'h00);
	vecs[19] = row(1, M128, 16'h7FFD, 8'h10, 16'h1234, 1, rom_loc(3, 16'h1234), 0, 5'h00);
	// ULA port, odd address ignored
	vecs[20] = row(1, M128, 16'h00FE, 8'h1D, 16'h4000, 0, bank_loc(5, 16'h4000), 0, 5'h1D);
	vecs[21] = row(0, M128, 16'h00FF, 8'h02, 16'h4000, 0, bank_loc(5, 16'h4000), 0, 5'h1D);
	vecs[22] = row(1, M48,  16'h00FE, 8'h0A, 16'h8000, 0, bank_loc(2, 16'h8000), 0, 5'h0A);
endfunction

`endif

//--- tests/tb_zx_mem_ctrl.sv
/*
 Testbench for zx_mem_ctrl with the default ROM_BASE.
 Paging table first, then turbo, back-pressure and pause gating.
*/
`timescale 1ns/1ns

module tb_zx_mem_ctrl;

	localparam logic [2:0] ROM_BASE = 3'b101;
	localparam int WINDOW = 256; // Cycles per pulse count

	logic                          clk_sys = 1'b0;
	logic                          reset;
	zx_pkg::machine_t              machine;
	logic [15:0]                   cpu_addr;
	logic [7:0]                    cpu_dout;
	logic                          io_wr;
	logic                          mem_wr;
	logic [4:0]                    speed_key;
	logic                          pause_key;
	logic                          ram_ready;
	logic [zx_pkg::RAM_ADDR_W-1:0] ram_addr;
	logic                          ram_we;
	logic                          ce_cpu_p;
	logic                          ce_cpu_n;
	logic                          cpu_en;
	logic [2:0]                    border_color;
	logic                          ear_out;
	logic                          mic_out;
	int                            errors = 0;
	int                            cycles = 0;

	`include "tb_vectors.svh"

	localparam int CYCLE_LIMIT = NUM_VECS * 40 + 5000;

	zx_mem_ctrl #(.ROM_BASE(ROM_BASE)) dut (.*);

	always #5 clk_sys = ~clk_sys;

	// Watchdog
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("CHECKS FAILED");
			$fatal(1, "Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		end
	end

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "Stopped at the first error");
		end
	endtask

	task automatic apply_reset(input zx_pkg::machine_t mach);
		@(posedge clk_sys);
		machine <= mach;
		reset   <= 1'b1;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	// ==============================
	// Paging table
	// ==============================
	task automatic apply_row(input int idx, input vec_t v);
		if (v.rst)
			apply_reset(v.mach);
		@(posedge clk_sys);
		cpu_addr <= v.port;
		cpu_dout <= v.data;
		io_wr    <= 1'b1;
		@(posedge clk_sys);
		io_wr <= 1'b0;
		repeat (2) @(posedge clk_sys); // Edge register, then page register
		cpu_addr <= v.probe;
		mem_wr   <= v.wr;
		@(negedge clk_sys);
		check_eq($sformatf("row %0d ram_addr", idx), ram_addr, v.exp_addr);
		check_eq($sformatf("row %0d ram_we", idx), ram_we, v.exp_we);
		check_eq($sformatf("row %0d border", idx), border_color, v.exp_ula[2:0]);
		check_eq($sformatf("row %0d mic", idx), mic_out, v.exp_ula[3]);
		check_eq($sformatf("row %0d ear", idx), ear_out, v.exp_ula[4]);
		@(posedge clk_sys);
		mem_wr <= 1'b0;
	endtask

	// ==============================
	// Turbo helpers
	// ==============================
	task automatic pulse_speed(input int bit_idx);
		@(posedge clk_sys);
		speed_key <= 5'd1 << bit_idx;
		@(posedge clk_sys);
		speed_key <= 5'd0;
	endtask

	task automatic pulse_pause();
		@(posedge clk_sys);
		pause_key <= 1'b1;
		@(posedge clk_sys);
		pause_key <= 1'b0;
	endtask

	task automatic wait_cpu_en(input logic level);
		@(negedge clk_sys);
		while (cpu_en !== level)
			@(negedge clk_sys);
	endtask

	task automatic count_pulses(output int np, output int nn);
		np = 0;
		nn = 0;
		repeat (WINDOW) begin
			@(negedge clk_sys);
			np += ce_cpu_p;
			nn += ce_cpu_n;
		end
	endtask

	// One cpu_p every 2*(mask+1) cycles
	function automatic int expected_count(input logic [4:0] mask);
		int m;
		m = mask;
		return WINDOW / (2 * (m + 1));
	endfunction

	task automatic run_turbo_checks();
		int np;
		int nn;
		apply_reset(M128);
		count_pulses(np, nn);
		check_eq("3.5 MHz ce_cpu_p count", np, expected_count(zx_pkg::TURBO_3M5));
		check_eq("3.5 MHz ce_cpu_n count", nn, expected_count(zx_pkg::TURBO_3M5));
		@(posedge clk_sys);
		ram_ready <= 1'b0; // No stall below 14 MHz
		count_pulses(np, nn);
		check_eq("3.5 MHz count, ram_ready low", np, expected_count(zx_pkg::TURBO_3M5));
		check_eq("cpu_en at 3.5 MHz, ram_ready low", cpu_en, 1'b1);
		@(posedge clk_sys);
		ram_ready <= 1'b1;
		pulse_speed(4);
		wait_cpu_en(1'b0);
		wait_cpu_en(1'b1);
		count_pulses(np, nn);
		check_eq("56 MHz ce_cpu_p count", np, expected_count(zx_pkg::TURBO_56M));
		check_eq("56 MHz ce_cpu_n count", nn, expected_count(zx_pkg::TURBO_56M));

		// 14 MHz back-pressure, then pause
		apply_reset(M128);
		pulse_speed(2);
		wait_cpu_en(1'b0);
		wait_cpu_en(1'b1);
		@(posedge clk_sys);
		ram_ready <= 1'b0;
		wait_cpu_en(1'b0);
		count_pulses(np, nn);
		check_eq("ce_cpu_p count during RAM stall", np, 0);
		@(posedge clk_sys);
		ram_ready <= 1'b1;
		wait_cpu_en(1'b1);
		count_pulses(np, nn);
		check_eq("14 MHz ce_cpu_p count", np, expected_count(zx_pkg::TURBO_14M));
		pulse_pause();
		wait_cpu_en(1'b0);
		count_pulses(np, nn);
		check_eq("ce_cpu_p count in pause", np, 0);
		pulse_pause();
		wait_cpu_en(1'b1);
		count_pulses(np, nn);
		check_eq("14 MHz count after pause", np, expected_count(zx_pkg::TURBO_14M));
	endtask

	initial begin
		reset     <= 1'b1;
		machine   <= zx_pkg::MACH_128;
		cpu_addr  <= 16'h0000;
		cpu_dout  <= 8'h00;
		io_wr     <= 1'b0;
		mem_wr    <= 1'b0;
		speed_key <= 5'd0;
		pause_key <= 1'b0;
		ram_ready <= 1'b1;
		fill_vectors();
		for (int i = 0; i < NUM_VECS; i++)
			apply_row(i, vecs[i]);
		run_turbo_checks();
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+tests
hdl/zx_pkg.sv
hdl/ce_divider.sv
hdl/speed_ctrl.sv
hdl/page_regs.sv
hdl/mem_map.sv
hdl/zx_mem_ctrl.sv
tests/tb_zx_mem_ctrl.sv
